// File: verif/fpMulStim.txt
# name x y rMode z ovrf udrf, all values hex; rMode 0 rne, 1 rtz, 2 rdn, 3 rup, 4 rmm
# Names starting with b2b are sent on the cycle right after the previous vector
rne_1p5x2 3FC00000 40000000 0 40400000 0 0
rne_1p1sq 3F8CCCCD 3F8CCCCD 0 3F9AE148 0 0
rne_1p5sq 3FC00000 3FC00000 0 40100000 0 0
rne_maxsig 3FFFFFFF 3FFFFFFF 0 407FFFFE 0 0
rup_maxsig 3FFFFFFF 3FFFFFFF 3 407FFFFF 0 0
rne_gs BF800001 3FC00001 0 BFC00003 0 0
rtz_gs BF800001 3FC00001 1 BFC00002 0 0
rdn_gs BF800001 3FC00001 2 BFC00003 0 0
rup_gs BF800001 3FC00001 3 BFC00002 0 0
rmm_gs BF800001 3FC00001 4 BFC00003 0 0
rup_gs_pos 3F800001 3FC00001 3 3FC00003 0 0
rne_tie 3F800003 3FC00000 0 3FC00004 0 0
rmm_tie 3F800003 3FC00000 4 3FC00005 0 0
mode7_tie 3F800003 3FC00000 7 3FC00004 0 0
zero_neg 80000000 3FC00000 0 80000000 0 0
sub_times_neg 00000001 C0000000 0 80000000 0 0
sub_sub 00400000 80400000 0 80000000 0 0
ovf_rne 7F000000 40000000 0 7F800000 1 0
ovf_rtz 7F000000 40000000 1 7F7FFFFF 1 0
ovf_rup_neg FF000000 40000000 3 FF7FFFFF 1 0
ovf_rdn_neg FF000000 40000000 2 FF800000 1 0
unf_minsq 00800000 00800000 3 00000000 0 1
unf_neg 80800000 3F000000 0 80000000 0 1
nan_snan 7F800001 00000000 0 7FC00000 0 0
inf_times_zero 7F800000 00000000 0 7FC00000 0 0
inf_times_sub FF800000 00000001 0 7FC00000 0 0
inf_times_neg 7F800000 C0000000 0 FF800000 0 0
b2b_a 40000000 40400000 0 40C00000 0 0
b2b_b 40400000 40400000 0 41100000 0 0
b2b_c 3F800000 BF800000 0 BF800000 0 0

// File: verilog.f
design/fpPkg.sv
design/boothMultiplier.sv
design/fpRound.sv
design/fpMulChecker.sv
design/fpMul.sv
verif/fpMulTb.sv

// File: Bender.yml
package:
  name: fp_mul

sources:
  - design/fpPkg.sv
  - design/boothMultiplier.sv
  - design/fpRound.sv
  - design/fpMulChecker.sv
  - design/fpMul.sv
  - target: test
    files:
      - verif/fpMulTb.sv

// File: verif/fpMulTb.sv
`timescale 1ns/1ps

module fpMulTb;

    localparam int TimeoutCycles = 20;
    localparam int Latency       = 2;

    logic          clk;
    logic          rst;
    logic          inVld;
    fpPkg::mulReqT req;
    logic          outVld;
    fpPkg::mulRspT rsp;

    int            cycleCount = 0;
    string         nameQ[$];
    fpPkg::mulRspT expQ[$];
    int            issueQ[$];

    fpMul #(
        .SigWidth(fpPkg::sigWidth)
    ) u_fpMul (
        .clk   (clk),
        .rst   (rst),
        .inVld (inVld),
        .req   (req),
        .outVld(outVld),
        .rsp   (rsp)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
    end

    task automatic failRun(input string reason);
        $display("%s", reason);
        $display("test failed");
        $fatal(1, "%s", reason);
    endtask

    task automatic checkZ(input string name, input fpPkg::fp32T expVal,
                          input fpPkg::fp32T actVal);
        if (actVal !== expVal) begin
            failRun($sformatf("Error %s z: expected %h, actual %h", name, expVal, actVal));
        end
    endtask

    task automatic checkFlag(input string name, input string flagName, input logic expVal,
                             input logic actVal);
        if (actVal !== expVal) begin
            failRun($sformatf("Error %s %s: expected %b, actual %b", name, flagName, expVal,
                              actVal));
        end
    endtask

    task automatic checkLatency(input string name, input int expVal, input int actVal);
        if (actVal != expVal) begin
            failRun($sformatf("Error %s latency: expected %0d, actual %0d", name, expVal,
                              actVal));
        end
    endtask

    // Results are sampled on the falling edge, away from the register updates
    always @(negedge clk) begin
        if (!rst) begin
            if (outVld) begin
                if (nameQ.size() == 0) begin
                    failRun("A result arrived while no vector was pending");
                end else begin
                    checkLatency(nameQ[0], Latency, cycleCount - issueQ[0]);
                    checkZ(nameQ[0], expQ[0].z, rsp.z);
                    checkFlag(nameQ[0], "ovrf", expQ[0].ovrf, rsp.ovrf);
                    checkFlag(nameQ[0], "udrf", expQ[0].udrf, rsp.udrf);
                    nameQ.delete(0);
                    expQ.delete(0);
                    issueQ.delete(0);
                end
            end else if (nameQ.size() != 0 && cycleCount - issueQ[0] > TimeoutCycles) begin
                failRun($sformatf("No result arrived for %s within %0d cycles", nameQ[0],
                                  TimeoutCycles));
            end
        end
    end

    initial begin
        int            fd;
        int            gap;
        int            fields;
        int            drainCycles;
        string         line;
        string         testName;
        fpPkg::fp32T   x;
        fpPkg::fp32T   y;
        fpPkg::fp32T   z;
        logic [2:0]    mode;
        logic          ovrf;
        logic          udrf;
        fpPkg::mulRspT expRsp;

        rst   = 1'b1;
        inVld = 1'b0;
        req   = '0;
        void'($urandom(52));
        fd = $fopen("verif/fpMulStim.txt", "r");
        if (fd == 0) begin
            failRun("Cannot open the stimulus file verif/fpMulStim.txt");
        end
        repeat (10) @(posedge clk);
        #2;
        rst = 1'b0;

        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 2 || line[0] == "#") begin
                continue;
            end
            fields = $sscanf(line, "%s %h %h %h %h %h %h", testName, x, y, mode, z, ovrf,
                             udrf);
            if (fields != 7) begin
                failRun($sformatf("Malformed stimulus line: %s", line));
            end
            // b2b vectors follow the previous one with no idle cycle
            gap = (testName.substr(0, 2) == "b2b") ? 0 : int'($urandom % 3);
            repeat (gap) begin
                @(posedge clk);
                #2;
                inVld = 1'b0;
            end
            @(posedge clk);
            #2;
            inVld     = 1'b1;
            req.x     = x;
            req.y     = y;
            req.rMode = fpPkg::roundModeT'(mode);
            expRsp.z    = z;
            expRsp.ovrf = ovrf;
            expRsp.udrf = udrf;
            nameQ.push_back(testName);
            expQ.push_back(expRsp);
            issueQ.push_back(cycleCount);
        end
        $fclose(fd);
        @(posedge clk);
        #2;
        inVld = 1'b0;

        drainCycles = 0;
        while (nameQ.size() != 0 && drainCycles < TimeoutCycles) begin
            @(posedge clk);
            drainCycles++;
        end
        if (nameQ.size() == 0) begin
            $display("test passed");
            $finish;
        end else begin
            failRun("Results still missing after the last vector");
        end
    end

endmodule

// File: design/fpMul.sv
`timescale 1ns/1ps

module fpMul #(
    parameter int SigWidth = fpPkg::sigWidth
) (
    input  logic          clk,
    input  logic          rst,
    input  logic          inVld,
    input  fpPkg::mulReqT req,
    output logic          outVld,
    output fpPkg::mulRspT rsp
);

    fpPkg::fpClassT  xClass;
    fpPkg::fpClassT  yClass;
    fpPkg::sigT      xSig;
    fpPkg::sigT      ySig;
    fpPkg::prodT     prod;
    fpPkg::expSumT   expSum;
    fpPkg::stageOneT stageOne;
    logic            stageOneVld;
    fpPkg::mulRspT   rspNext;
    fpPkg::fp32T     rspX;
    fpPkg::fp32T     rspY;

    function automatic fpPkg::fpClassT classify(input fpPkg::fp32T v);
        fpPkg::expT     e;
        fpPkg::fracT    f;
        fpPkg::fpClassT c;

        e        = v[30:23];
        f        = v[22:0];
        c.isZero = (e == '0);
        c.isSub  = (e == '0) && (f != '0);
        c.isInf  = (e == '1) && (f == '0);
        c.isNan  = (e == '1) && (f != '0);
        return c;
    endfunction

    assign xClass = classify(req.x);
    assign yClass = classify(req.y);

    // Flushed operands feed a zero significand
    assign xSig = xClass.isZero ? '0 : {1'b1, req.x[22:0]};
    assign ySig = yClass.isZero ? '0 : {1'b1, req.y[22:0]};

    assign expSum = fpPkg::expSumT'({2'b00, req.x[30:23]}) +
                    fpPkg::expSumT'({2'b00, req.y[30:23]}) -
                    fpPkg::expSumT'(fpPkg::expBias);

    boothMultiplier #(
        .SigWidth(SigWidth)
    ) u_boothMultiplier (
        .multiplicand(xSig),
        .multiplier  (ySig),
        .product     (prod)
    );

    // Stage 1
    always_ff @(posedge clk) begin
        if (rst) begin
            stageOneVld <= 1'b0;
        end else begin
            stageOneVld <= inVld;
        end
    end

    always_ff @(posedge clk) begin
        if (inVld) begin
            stageOne.req    <= req;
            stageOne.xClass <= xClass;
            stageOne.yClass <= yClass;
            stageOne.prod   <= prod;
            stageOne.expSum <= expSum;
        end
    end

    fpRound u_fpRound (
        .stage(stageOne),
        .rsp  (rspNext)
    );

    // Stage 2 output register
    always_ff @(posedge clk) begin
        if (rst) begin
            outVld <= 1'b0;
            rsp    <= '0;
        end else begin
            outVld <= stageOneVld;
            if (stageOneVld) begin
                rsp <= rspNext;
            end
        end
    end

    // Operands kept alongside rsp for the checker
    always_ff @(posedge clk) begin
        if (stageOneVld) begin
            rspX <= stageOne.req.x;
            rspY <= stageOne.req.y;
        end
    end

    fpMulChecker u_fpMulChecker (
        .clk     (clk),
        .rst     (rst),
        .stage   (stageOne),
        .stageVld(stageOneVld),
        .rsp     (rsp),
        .rspX    (rspX),
        .rspY    (rspY),
        .rspVld  (outVld)
    );

endmodule

// File: design/fpMulChecker.sv
`timescale 1ns/1ps

module fpMulChecker (
    input logic            clk,
    input logic            rst,
    input fpPkg::stageOneT stage,
    input logic            stageVld,
    input fpPkg::mulRspT   rsp,
    input fpPkg::fp32T     rspX,
    input fpPkg::fp32T     rspY,
    input logic            rspVld
);

    // One extra digit so the unsigned multiplier needs no correction term
    localparam int RefDigits = fpPkg::sigWidth / 2 + 1;

    logic        xSub;
    logic        xZero;
    logic        xInfNan;
    logic        ySub;
    logic        yZero;
    logic        yInfNan;
    logic        stageNormal;
    fpPkg::fp32T signedZero;
    fpPkg::prodT refProd;

    function automatic fpPkg::prodT boothRef(input fpPkg::sigT mcand,
                                             input fpPkg::sigT mplier);
        logic [fpPkg::sigWidth+2:0] mPad;
        fpPkg::prodT                mExt;
        fpPkg::prodT                term;
        fpPkg::prodT                acc;
        logic [2:0]                 triplet;

        mExt = fpPkg::prodT'(mcand);
        mPad = {2'b00, mplier, 1'b0};
        acc  = '0;
        for (int i = 0; i < RefDigits; i++) begin
            triplet = mPad[2*i +: 3];
            case (triplet)
                3'b001,
                3'b010:  term = mExt;
                3'b011:  term = mExt << 1;
                3'b100:  term = -(mExt << 1);
                3'b101,
                3'b110:  term = -mExt;
                default: term = '0;
            endcase
            acc = acc + (term << (2 * i));
        end
        return acc;
    endfunction

    // Classification of the operands that produced rsp
    assign xSub    = (rspX[30:23] == 8'h00) && (rspX[22:0] != '0);
    assign xZero   = (rspX[30:0] == '0);
    assign xInfNan = (rspX[30:23] == 8'hFF);
    assign ySub    = (rspY[30:23] == 8'h00) && (rspY[22:0] != '0);
    assign yZero   = (rspY[30:0] == '0);
    assign yInfNan = (rspY[30:23] == 8'hFF);

    assign signedZero = {rspX[31] ^ rspY[31], 31'd0};

    // Both stage-1 operands normal
    assign stageNormal = (stage.req.x[30:23] != 8'h00) && (stage.req.x[30:23] != 8'hFF) &&
                         (stage.req.y[30:23] != 8'h00) && (stage.req.y[30:23] != 8'hFF);

    assign refProd = boothRef({1'b1, stage.req.x[22:0]}, {1'b1, stage.req.y[22:0]});

    mulSubTimesNum: assert property (@(posedge clk) disable iff (rst)
        rspVld && ((xSub && !yInfNan) || (ySub && !xInfNan)) |-> rsp.z == signedZero)
        else $error("Subnormal times finite gave %h", rsp.z);

    mulSubTimesSub: assert property (@(posedge clk) disable iff (rst)
        rspVld && xSub && ySub |-> rsp.z == signedZero)
        else $error("Subnormal times subnormal gave %h", rsp.z);

    mulZeroTimesZero: assert property (@(posedge clk) disable iff (rst)
        rspVld && xZero && yZero |-> rsp.z == signedZero)
        else $error("Zero times zero gave %h", rsp.z);

    mulZeroTimesNum: assert property (@(posedge clk) disable iff (rst)
        rspVld && ((xZero && !yInfNan) || (yZero && !xInfNan)) |-> rsp.z == signedZero)
        else $error("Zero times finite gave %h", rsp.z);

    boothEncode: assert property (@(posedge clk) disable iff (rst)
        stageVld && stageNormal |-> stage.prod == refProd)
        else $error("Stage-1 product %h, expected %h", stage.prod, refProd);

    flagsExclusive: assert property (@(posedge clk) disable iff (rst)
        rspVld |-> !(rsp.ovrf && rsp.udrf))
        else $error("Overflow and underflow raised together");

endmodule

// File: design/fpRound.sv
`timescale 1ns/1ps

module fpRound (
    input  fpPkg::stageOneT stage,
    output fpPkg::mulRspT   rsp
);

    logic                   sign;
    fpPkg::fracT            fracNorm;
    logic                   guard;
    logic                   sticky;
    fpPkg::expSumT          expNorm;
    logic                   roundUp;
    logic [fpPkg::sigWidth:0] sigRound;
    fpPkg::expSumT          expFinal;
    fpPkg::fracT            fracFinal;
    logic                   toInf;
    logic                   anyNan;
    logic                   infTimesZero;
    logic                   anyInf;
    logic                   anyZero;

    assign sign = stage.req.x[31] ^ stage.req.y[31];

    // Product of two [1,2) significands lies in [1,4)
    always_comb begin
        if (stage.prod[47]) begin
            fracNorm = stage.prod[46:24];
            guard    = stage.prod[23];
            sticky   = |stage.prod[22:0];
            expNorm  = stage.expSum + 10'sd1;
        end else begin
            fracNorm = stage.prod[45:23];
            guard    = stage.prod[22];
            sticky   = |stage.prod[21:0];
            expNorm  = stage.expSum;
        end
    end

    always_comb begin
        case (stage.req.rMode)
            fpPkg::rtz: roundUp = 1'b0;
            fpPkg::rdn: roundUp = sign & (guard | sticky);
            fpPkg::rup: roundUp = ~sign & (guard | sticky);
            fpPkg::rmm: roundUp = guard;
            // rne and any unused code
            default:    roundUp = guard & (sticky | fracNorm[0]);
        endcase
    end

    assign sigRound = {1'b0, 1'b1, fracNorm} + {{fpPkg::sigWidth{1'b0}}, roundUp};

    // Carry out of rounding leaves 10.000... so shift right by one
    always_comb begin
        if (sigRound[fpPkg::sigWidth]) begin
            expFinal  = expNorm + 10'sd1;
            fracFinal = sigRound[23:1];
        end else begin
            expFinal  = expNorm;
            fracFinal = sigRound[22:0];
        end
    end

    // Overflow saturates to infinity only when the mode rounds away from zero
    always_comb begin
        case (stage.req.rMode)
            fpPkg::rtz: toInf = 1'b0;
            fpPkg::rdn: toInf = sign;
            fpPkg::rup: toInf = ~sign;
            default:    toInf = 1'b1;
        endcase
    end

    assign anyNan       = stage.xClass.isNan | stage.yClass.isNan;
    assign infTimesZero = (stage.xClass.isInf & stage.yClass.isZero) |
                          (stage.yClass.isInf & stage.xClass.isZero);
    assign anyInf       = stage.xClass.isInf | stage.yClass.isInf;
    assign anyZero      = stage.xClass.isZero | stage.yClass.isZero;

    always_comb begin
        rsp = '0;
        if (anyNan || infTimesZero) begin
            rsp.z = fpPkg::qNan;
        end else if (anyInf) begin
            rsp.z = {sign, fpPkg::posInf[30:0]};
        end else if (anyZero) begin
            rsp.z = {sign, 31'd0};
        end else if (expFinal > 10'sd254) begin
            rsp.ovrf = 1'b1;
            rsp.z    = toInf ? {sign, fpPkg::posInf[30:0]} : {sign, fpPkg::maxFinite[30:0]};
        end else if (expFinal < 10'sd1) begin
            // Flush to zero below the normal range
            rsp.udrf = 1'b1;
            rsp.z    = {sign, 31'd0};
        end else begin
            rsp.z = {sign, expFinal[7:0], fracFinal};
        end
    end

endmodule

// File: design/boothMultiplier.sv
`timescale 1ns/1ps

module boothMultiplier #(
    parameter int SigWidth = 24
) (
    input  logic [SigWidth-1:0]   multiplicand,
    input  logic [SigWidth-1:0]   multiplier,
    output logic [2*SigWidth-1:0] product
);

    localparam int Digits    = SigWidth / 2;
    localparam int ProdWidth = 2 * SigWidth;

    logic [ProdWidth-1:0] mcandOne;
    logic [ProdWidth-1:0] mcandTwo;
    logic [SigWidth:0]    mplierPad;
    logic [ProdWidth-1:0] partials [Digits];
    logic [ProdWidth-1:0] topFix;

    // Multiplicand is unsigned, so it is zero extended
    assign mcandOne  = ProdWidth'(multiplicand);
    assign mcandTwo  = mcandOne << 1;
    // Implicit zero to the right of bit 0 for the first digit
    assign mplierPad = {multiplier, 1'b0};

    for (genvar i = 0; i < Digits; i++) begin : gDigit
        logic [2:0]           code;
        logic [ProdWidth-1:0] select;

        assign code = mplierPad[2*i +: 3];

        // Radix-4 recoding into a digit from -2 to +2
        always_comb begin
            case (code)
                3'b001,
                3'b010:  select = mcandOne;
                3'b011:  select = mcandTwo;
                3'b100:  select = -mcandTwo;
                3'b101,
                3'b110:  select = -mcandOne;
                default: select = '0;
            endcase
        end

        assign partials[i] = select << (2 * i);
    end

    // The digits read the multiplier as two's complement, so a set MSB
    // needs M * 2^SigWidth added back to get the unsigned product
    assign topFix = multiplier[SigWidth-1] ? (mcandOne << SigWidth) : '0;

    always_comb begin
        product = topFix;
        for (int i = 0; i < Digits; i++) begin
            product = product + partials[i];
        end
    end

    // Recoded sum must equal the plain integer product
    always_comb begin
        boothProductExact: assert final (
            (multiplicand == '0) || (multiplier == '0) ||
            (product == mcandOne * ProdWidth'(multiplier)))
        else
            $error("Booth product %h differs for %h x %h", product, multiplicand,
                   multiplier);
    end

endmodule

// File: design/fpPkg.sv
package fpPkg;

    // Significand width including the hidden one
    localparam int sigWidth = 24;
    localparam int expBias  = 127;

    typedef logic [31:0]           fp32T;
    typedef logic [7:0]            expT;
    typedef logic [22:0]           fracT;
    typedef logic [sigWidth-1:0]   sigT;
    typedef logic [2*sigWidth-1:0] prodT;

    // Exponent sum minus the bias is wide enough for overflow and underflow
    typedef logic signed [9:0] expSumT;

    typedef enum logic [2:0] {
        rne = 3'd0,
        rtz = 3'd1,
        rdn = 3'd2,
        rup = 3'd3,
        rmm = 3'd4
    } roundModeT;

    // isZero also covers subnormals because they are flushed
    typedef struct packed {
        logic isZero;
        logic isSub;
        logic isInf;
        logic isNan;
    } fpClassT;

    typedef struct packed {
        fp32T      x;
        fp32T      y;
        roundModeT rMode;
    } mulReqT;

    typedef struct packed {
        fp32T z;
        logic ovrf;
        logic udrf;
    } mulRspT;

    // Contents of the first pipeline register
    typedef struct packed {
        mulReqT  req;
        fpClassT xClass;
        fpClassT yClass;
        prodT    prod;
        expSumT  expSum;
    } stageOneT;

    localparam fp32T qNan      = 32'h7FC0_0000;
    localparam fp32T posInf    = 32'h7F80_0000;
    localparam fp32T maxFinite = 32'h7F7F_FFFF;

endpackage
